/* run_sim.sh */
#!/usr/bin/env bash
# build and run the search control testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f vlog.f \
      --top-module search_ctrl_tb -Mdir obj_dir -o search_ctrl_sim; then
   echo "verilator build failed"
   exit 1
fi

output="$(./obj_dir/search_ctrl_sim +verilator+error+limit+100 2>&1)"
status=$?
echo "$output"

if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^Simulation PASSED$" <<< "$output"; then
   exit 0
fi
echo "pass message not found"
exit 1

/* src/ctrl_read_mux.sv */
// -------------------------------------------------
// registered readback mux over the control map
// -------------------------------------------------
`timescale 1ns/100ps

module ctrl_read_mux
#(
   parameter int MOVE_INDEX_WIDTH = 7,
   parameter int HALF_MOVE_WIDTH  = 10
)
(
   input  logic                            clk,
   input  logic                            rst_n,
   input  search_bus_pkg::reg_addr_t       addr,
   input  logic                            new_board_valid,
   input  logic                            clear_moves,
   input  logic                            soft_reset,
   input  logic [MOVE_INDEX_WIDTH-1:0]     move_index,
   input  logic [HALF_MOVE_WIDTH-1:0]      half_move,
   input  search_pos_pkg::position_t       position,
   input  search_pos_pkg::movegen_status_t status,
   input  search_pos_pkg::tt_result_t      tt,
   output logic [127:0]                    rdata
);

   localparam int ew = search_pos_pkg::eval_width;

   logic [127:0] rd_word;

   function automatic logic [31:0] sext_eval(input logic signed [ew-1:0] v);
      return {{(32 - ew){v[ew-1]}}, v};
   endfunction

   always_comb
   begin
      rd_word = '0;
      case (addr)
         search_bus_pkg::addr_command:
         begin
            rd_word[0]  = new_board_valid;
            rd_word[1]  = clear_moves;
            rd_word[2]  = status.moves_ready;
            rd_word[3]  = status.move_ready;
            rd_word[4]  = status.initial_stalemate;
            rd_word[5]  = status.initial_mate;
            rd_word[7]  = status.idle;
            rd_word[31] = soft_reset;
         end
         search_bus_pkg::addr_move_index:      rd_word[MOVE_INDEX_WIDTH-1:0] = move_index;
         search_bus_pkg::addr_position:
            rd_word[8:0] = {position.white_to_move, position.castle_mask,
                            position.en_passant_col};
         search_bus_pkg::addr_half_move:       rd_word[HALF_MOVE_WIDTH-1:0] = half_move;
         search_bus_pkg::addr_attack_white_lo: rd_word[31:0] = status.white_attack[31:0];
         search_bus_pkg::addr_attack_white_hi: rd_word[31:0] = status.white_attack[63:32];
         search_bus_pkg::addr_attack_black_lo: rd_word[31:0] = status.black_attack[31:0];
         search_bus_pkg::addr_attack_black_hi: rd_word[31:0] = status.black_attack[63:32];
         search_bus_pkg::addr_move_flags:      rd_word[6:0] = status.flags; // pv on top
         search_bus_pkg::addr_mg_position:
            rd_word[8:0] = {status.white_to_move, status.castle_mask, status.en_passant_col};
         search_bus_pkg::addr_eval:            rd_word[31:0] = sext_eval(status.eval);
         search_bus_pkg::addr_move_count:
            rd_word[MOVE_INDEX_WIDTH-1:0] = status.move_count[MOVE_INDEX_WIDTH-1:0];
         search_bus_pkg::addr_initial_eval:    rd_word[31:0] = sext_eval(status.initial_eval);
         search_bus_pkg::addr_uci:
            rd_word[19:0] = {status.uci[15:12], 1'b0, status.uci[11:9], 1'b0,
                             status.uci[8:6], 1'b0, status.uci[5:3], 1'b0, status.uci[2:0]};
         search_bus_pkg::addr_tt_result:
            rd_word[63:0] = {tt.collision, tt.result.flag, tt.entry_valid, tt.result.nodes,
                             tt.result.depth, tt.result.eval};
         search_bus_pkg::addr_tt_status:       rd_word[1:0] = {tt.capture, tt.idle};
         default:                              rd_word = '0;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         rdata <= '0;
      else
         rdata <= rd_word;
   end

endmodule

/* src/ctrl_write_decode.sv */
// -------------------------------------------------
// write decode for the search control registers
// qualifies a host write and raises one select
// -------------------------------------------------
`timescale 1ns/100ps

module ctrl_write_decode
(
   input  search_bus_pkg::bus_req_t   req,
   output search_bus_pkg::write_sel_t sel
);

   search_bus_pkg::reg_addr_t wr_addr;
   logic                      wr_valid;

   assign wr_addr  = req.addr[17:4];
   assign wr_valid = req.en && (req.be != '0); // any lane enabled

   always_comb
   begin
      sel      = '0;
      sel.be   = req.be;
      sel.data = req.wdata;
      if (wr_valid)
      begin
         case (wr_addr)
            search_bus_pkg::addr_command:
               sel.command = 1'b1;
            search_bus_pkg::addr_move_index:
               sel.move_index = 1'b1;
            search_bus_pkg::addr_position:
               sel.position = 1'b1;
            search_bus_pkg::addr_half_move:
               sel.half_move = 1'b1;
            search_bus_pkg::addr_board_lo:
               sel.board_lo = 1'b1;
            search_bus_pkg::addr_board_hi:
               sel.board_hi = 1'b1;
            search_bus_pkg::addr_tt_entry:
               sel.tt_entry = 1'b1;
            search_bus_pkg::addr_tt_strobe:
               sel.tt_strobe = 1'b1;
            default:
            begin
               // unmapped or read-only writes are dropped
            end
         endcase
      end
   end

endmodule

/* src/position_regs.sv */
// -------------------------------------------------
// command, move index and position registers
// board halves merged under byte enables
// -------------------------------------------------
`timescale 1ns/100ps

module position_regs
#(
   parameter int MOVE_INDEX_WIDTH = 7,
   parameter int HALF_MOVE_WIDTH  = 10
)
(
   input  logic                              clk,
   input  logic                              rst_n,
   input  search_bus_pkg::write_sel_t        sel,
   output logic                              new_board_valid,
   output logic                              clear_moves,
   output logic                              soft_reset,
   output logic [MOVE_INDEX_WIDTH-1:0]       move_index,
   output logic [HALF_MOVE_WIDTH-1:0]        half_move,
   output search_pos_pkg::position_t         position
);

   logic [127:0] word;

   assign word = sel.data; // flat view for narrow fields

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         new_board_valid <= 1'b0;
         clear_moves     <= 1'b0;
         soft_reset      <= 1'b0;
         move_index      <= '0;
         half_move       <= '0;
      end
      else
      begin
         if (sel.command)
         begin
            new_board_valid <= word[0];
            clear_moves     <= word[1];
            soft_reset      <= word[31];
         end
         if (sel.move_index)
            move_index <= word[MOVE_INDEX_WIDTH-1:0];
         if (sel.half_move)
            half_move <= word[HALF_MOVE_WIDTH-1:0];
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         position <= '0;
      else
      begin
         if (sel.position)
         begin
            position.white_to_move  <= word[8];
            position.castle_mask    <= word[7:4];
            position.en_passant_col <= word[3:0];
         end
         // each byte lane holds two squares
         for (int b = 0; b < search_bus_pkg::data_bytes; b++)
         begin
            if (sel.board_lo && sel.be[b])
               position.board[2*b +: 2] <= sel.data.lanes[b];
            if (sel.board_hi && sel.be[b])
               position.board[32 + 2*b +: 2] <= sel.data.lanes[b]; // bits 255:128
         end
      end
   end

endmodule

/* src/search_bus_pkg.sv */
// -------------------------------------------------
// host register bus types and register address map
// -------------------------------------------------
package search_bus_pkg;

   localparam int data_bytes = 16;

   typedef logic [13:0] reg_addr_t; // bus address bits 17:4

   localparam reg_addr_t addr_command         = 14'd0;
   localparam reg_addr_t addr_move_index      = 14'd1;
   localparam reg_addr_t addr_position        = 14'd2;
   localparam reg_addr_t addr_half_move       = 14'd3;
   localparam reg_addr_t addr_board_lo        = 14'd8;
   localparam reg_addr_t addr_board_hi        = 14'd9;
   localparam reg_addr_t addr_attack_white_lo = 14'd128;
   localparam reg_addr_t addr_attack_white_hi = 14'd129;
   localparam reg_addr_t addr_attack_black_lo = 14'd130;
   localparam reg_addr_t addr_attack_black_hi = 14'd131;
   localparam reg_addr_t addr_move_flags      = 14'd132;
   localparam reg_addr_t addr_mg_position     = 14'd133;
   localparam reg_addr_t addr_eval            = 14'd134;
   localparam reg_addr_t addr_move_count      = 14'd135;
   localparam reg_addr_t addr_initial_eval    = 14'd136;
   localparam reg_addr_t addr_uci             = 14'd139;
   localparam reg_addr_t addr_tt_result       = 14'd512;
   localparam reg_addr_t addr_tt_status       = 14'd513;
   localparam reg_addr_t addr_tt_entry        = 14'd520;
   localparam reg_addr_t addr_tt_strobe       = 14'd521;

   // one data word, seen as byte lanes or as a table entry
   typedef union packed
   {
      logic [data_bytes-1:0][7:0] lanes;
      struct packed
      {
         logic [63:0]               reserved;
         search_pos_pkg::tt_entry_t entry;
      } tt_view;
   } tt_word_u;

   typedef struct packed
   {
      logic [17:0]           addr;
      tt_word_u              wdata;
      logic                  en;
      logic [data_bytes-1:0] be;
   } bus_req_t;

   typedef struct packed
   {
      logic                  command;
      logic                  move_index;
      logic                  position;
      logic                  half_move;
      logic                  board_lo;
      logic                  board_hi;
      logic                  tt_entry;
      logic                  tt_strobe;
      logic [data_bytes-1:0] be;
      tt_word_u              data;
   } write_sel_t;

endpackage

/* src/search_ctrl_top.sv */
// -------------------------------------------------
// search accelerator host control block
// decode, register stages and readback
// -------------------------------------------------
`timescale 1ns/100ps

module search_ctrl_top
#(
   parameter int MOVE_INDEX_WIDTH = 7,
   parameter int HALF_MOVE_WIDTH  = 10
)
(
   input  logic                            clk,
   input  logic                            rst_n,
   input  search_bus_pkg::bus_req_t        req,
   input  search_pos_pkg::movegen_status_t status,
   input  search_pos_pkg::tt_result_t      tt_result,
   output logic [127:0]                    rdata,
   output logic                            new_board_valid,
   output logic                            clear_moves,
   output logic                            soft_reset,
   output logic [MOVE_INDEX_WIDTH-1:0]     move_index,
   output logic [HALF_MOVE_WIDTH-1:0]      half_move,
   output search_pos_pkg::position_t       position, // also the table request position
   output search_pos_pkg::tt_entry_t       tt_entry,
   output search_pos_pkg::tt_cmd_t         tt_cmd
);

   search_bus_pkg::write_sel_t sel;
   search_bus_pkg::reg_addr_t  rd_addr;

   assign rd_addr = req.addr[17:4]; // read address sampled every clock

   ctrl_write_decode ctrl_write_decode_i
   (
      .req (req),
      .sel (sel)
   );

   position_regs
   #(
      .MOVE_INDEX_WIDTH (MOVE_INDEX_WIDTH),
      .HALF_MOVE_WIDTH  (HALF_MOVE_WIDTH)
   )
   position_regs_i
   (
      .clk             (clk),
      .rst_n           (rst_n),
      .sel             (sel),
      .new_board_valid (new_board_valid),
      .clear_moves     (clear_moves),
      .soft_reset      (soft_reset),
      .move_index      (move_index),
      .half_move       (half_move),
      .position        (position)
   );

   tt_request_regs tt_request_regs_i
   (
      .clk   (clk),
      .rst_n (rst_n),
      .sel   (sel),
      .entry (tt_entry),
      .cmd   (tt_cmd)
   );

   ctrl_read_mux
   #(
      .MOVE_INDEX_WIDTH (MOVE_INDEX_WIDTH),
      .HALF_MOVE_WIDTH  (HALF_MOVE_WIDTH)
   )
   ctrl_read_mux_i
   (
      .clk             (clk),
      .rst_n           (rst_n),
      .addr            (rd_addr),
      .new_board_valid (new_board_valid),
      .clear_moves     (clear_moves),
      .soft_reset      (soft_reset),
      .move_index      (move_index),
      .half_move       (half_move),
      .position        (position),
      .status          (status),
      .tt              (tt_result),
      .rdata           (rdata)
   );

endmodule

/* src/search_pos_pkg.sv */
// -------------------------------------------------
// chess position, transposition entry and move
// generator status types
// -------------------------------------------------
package search_pos_pkg;

   localparam int eval_width = 24;
   localparam int move_count_max = 16; // widest move count carried

   typedef logic [63:0][3:0] board_t; // 64 squares, 4 bits each

   typedef struct packed
   {
      board_t     board;
      logic       white_to_move;
      logic [3:0] castle_mask;
      logic [3:0] en_passant_col;
   } position_t;

   typedef enum logic [1:0]
   {
      tt_exact = 2'd0,
      tt_lower = 2'd1,
      tt_upper = 2'd2
   } tt_flag_e;

   typedef struct packed
   {
      logic                          capture; // bit 63
      tt_flag_e                      flag;
      logic                          valid;
      logic [27:0]                   nodes;
      logic [7:0]                    depth;
      logic signed [eval_width-1:0]  eval; // bit 0 up
   } tt_entry_t;

   typedef struct packed
   {
      logic clear;
      logic hash_only;
      logic store;
      logic lookup;
   } tt_cmd_t;

   typedef struct packed
   {
      logic      entry_valid;
      logic      collision;
      logic      idle;
      logic      capture;
      tt_entry_t result;
   } tt_result_t;

   typedef struct packed
   {
      logic pv;
      logic insufficient_material;
      logic fifty_move;
      logic thrice_rep;
      logic black_in_check;
      logic white_in_check;
      logic capture;
   } move_flags_t;

   typedef struct packed
   {
      logic                         moves_ready; // all moves generated
      logic                         move_ready; // indexed move valid
      logic                         idle;
      logic                         initial_mate;
      logic                         initial_stalemate;
      logic [63:0]                  white_attack;
      logic [63:0]                  black_attack;
      move_flags_t                  flags;
      logic                         white_to_move;
      logic [3:0]                   castle_mask;
      logic [3:0]                   en_passant_col;
      logic signed [eval_width-1:0] eval;
      logic signed [eval_width-1:0] initial_eval;
      logic [15:0]                  uci;
      logic [move_count_max-1:0]    move_count; // low MOVE_INDEX_WIDTH bits used
   } movegen_status_t;

endpackage

/* src/tt_request_regs.sv */
// -------------------------------------------------
// transposition table request staging
// entry register and self-clearing table strobes
// -------------------------------------------------
`timescale 1ns/100ps

module tt_request_regs
(
   input  logic                       clk,
   input  logic                       rst_n,
   input  search_bus_pkg::write_sel_t sel,
   output search_pos_pkg::tt_entry_t  entry,
   output search_pos_pkg::tt_cmd_t    cmd
);

   search_pos_pkg::tt_entry_t entry_in;

   always_comb
   begin
      entry_in       = sel.data.tt_view.entry;
      entry_in.valid = 1'b1; // host entry always valid
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         entry <= '0;
      else if (sel.tt_entry)
         entry <= entry_in;
   end

   // strobes live one cycle, then drop
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         cmd <= '0;
      else if (sel.tt_strobe)
         cmd <= search_pos_pkg::tt_cmd_t'(sel.data.lanes[0][3:0]);
      else
         cmd <= '0;
   end

endmodule

/* test/search_ctrl_asserts.sv */
// -------------------------------------------------
// bound checks on table strobes and reset values
// -------------------------------------------------
`timescale 1ns/100ps

module search_ctrl_asserts
(
   input logic                     clk,
   input logic                     rst_n,
   input search_bus_pkg::bus_req_t req,
   input search_pos_pkg::tt_cmd_t  tt_cmd,
   input logic                     new_board_valid,
   input logic                     clear_moves,
   input logic                     soft_reset
);

   int         fail_count = 0;
   logic [3:0] cmd_bits;
   logic       strobe_write;

   assign cmd_bits     = tt_cmd;
   assign strobe_write = req.en && (req.be != '0) &&
                         (req.addr[17:4] == search_bus_pkg::addr_tt_strobe);

   strobe_single: assert property (@(posedge clk) disable iff (!rst_n)
                                   (cmd_bits & $past(cmd_bits)) == 4'h0)
   else
   begin
      fail_count++;
      $error("table strobe high two cycles in a row");
   end

   reset_quiet: assert property (@(posedge clk) !rst_n |=>
                                 (cmd_bits == 4'h0) && !new_board_valid && !clear_moves &&
                                 !soft_reset)
   else
   begin
      fail_count++;
      $error("strobe or command bit high during reset");
   end

   // strobes only come from a strobe register write
   strobe_origin: assert property (@(posedge clk) disable iff (!rst_n)
                                   (cmd_bits != 4'h0) |-> $past(strobe_write))
   else
   begin
      fail_count++;
      $error("table strobe without a write to the strobe register");
   end

endmodule

/* test/search_ctrl_tb.sv */
// -------------------------------------------------
// testbench for the search accelerator control block
// -------------------------------------------------
`timescale 1ns/100ps

module search_ctrl_tb;

   localparam int mi_w            = 7;
   localparam int hm_w            = 10;
   localparam int reset_cycles    = 8;
   localparam int n_iter          = 22;
   localparam int cycles_per_iter = 60; // one pass of writes and reads, rounded up
   localparam int watchdog_cycles = reset_cycles + 3 * n_iter * cycles_per_iter;

   localparam search_bus_pkg::reg_addr_t read_addrs [17] = '{
      search_bus_pkg::addr_command, search_bus_pkg::addr_move_index,
      search_bus_pkg::addr_position, search_bus_pkg::addr_half_move, 14'd4,
      search_bus_pkg::addr_attack_white_lo, search_bus_pkg::addr_attack_white_hi,
      search_bus_pkg::addr_attack_black_lo, search_bus_pkg::addr_attack_black_hi,
      search_bus_pkg::addr_move_flags, search_bus_pkg::addr_mg_position,
      search_bus_pkg::addr_eval, search_bus_pkg::addr_move_count,
      search_bus_pkg::addr_initial_eval, search_bus_pkg::addr_uci,
      search_bus_pkg::addr_tt_result, search_bus_pkg::addr_tt_status};

   logic                            clk;
   logic                            rst_n;
   search_bus_pkg::bus_req_t        req;
   search_pos_pkg::movegen_status_t status;
   search_pos_pkg::tt_result_t      tt_result;
   logic [127:0]                    rdata;
   logic                            new_board_valid;
   logic                            clear_moves;
   logic                            soft_reset;
   logic [mi_w-1:0]                 move_index;
   logic [hm_w-1:0]                 half_move;
   search_pos_pkg::position_t       position;
   search_pos_pkg::tt_entry_t       tt_entry;
   search_pos_pkg::tt_cmd_t         tt_cmd;

   integer                          seed = 32'h17fd_197b;

   // reference model state
   logic                            exp_nbv;
   logic                            exp_clr;
   logic                            exp_srst;
   logic [mi_w-1:0]                 exp_mi;
   logic [hm_w-1:0]                 exp_hm;
   logic [8:0]                      exp_pos; // side, castle, en passant
   logic [255:0]                    exp_board;
   logic [63:0]                     exp_entry;
   logic [3:0]                      exp_cmd;
   search_pos_pkg::movegen_status_t st_v;
   search_pos_pkg::tt_result_t      tr_v;

   bind search_ctrl_top search_ctrl_asserts search_ctrl_asserts_i
   (
      .clk             (clk),
      .rst_n           (rst_n),
      .req             (req),
      .tt_cmd          (tt_cmd),
      .new_board_valid (new_board_valid),
      .clear_moves     (clear_moves),
      .soft_reset      (soft_reset)
   );

   search_ctrl_top
   #(
      .MOVE_INDEX_WIDTH (mi_w),
      .HALF_MOVE_WIDTH  (hm_w)
   )
   search_ctrl_top_i
   (
      .clk             (clk),
      .rst_n           (rst_n),
      .req             (req),
      .status          (status),
      .tt_result       (tt_result),
      .rdata           (rdata),
      .new_board_valid (new_board_valid),
      .clear_moves     (clear_moves),
      .soft_reset      (soft_reset),
      .move_index      (move_index),
      .half_move       (half_move),
      .position        (position),
      .tt_entry        (tt_entry),
      .tt_cmd          (tt_cmd)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   initial
   begin
      repeat (watchdog_cycles) @(posedge clk);
      $display("watchdog expired before the tests completed");
      $display("Simulation FAILED");
      $fatal(1, "timeout");
   end

   always @(negedge clk)
   begin
      if (search_ctrl_top_i.search_ctrl_asserts_i.fail_count != 0)
      begin
         $display("a bound assertion on the control block failed");
         $display("Simulation FAILED");
         $fatal(1, "bound assertion");
      end
   end

   function automatic logic [127:0] rand_data();
      return {$random(seed), $random(seed), $random(seed), $random(seed)};
   endfunction

   function automatic logic [15:0] rand_be();
      logic [31:0] r;
      r = $random(seed);
      return r[15:0];
   endfunction

   task automatic check_value(input string name, input logic [255:0] exp,
                              input logic [255:0] act);
      assert (exp == act)
      else
      begin
         $display("Fail %s expected %h actual %h", name, exp, act);
         $display("Simulation FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic model_write(input search_bus_pkg::reg_addr_t a, input logic [127:0] d,
                              input logic [15:0] be);
      int base;
      exp_cmd = 4'h0; // strobes from an earlier write are gone
      if (be != '0)
      begin
         case (a)
            search_bus_pkg::addr_command:
            begin
               exp_nbv  = d[0];
               exp_clr  = d[1];
               exp_srst = d[31];
            end
            search_bus_pkg::addr_move_index: exp_mi = d[mi_w-1:0];
            search_bus_pkg::addr_position:   exp_pos = d[8:0];
            search_bus_pkg::addr_half_move:  exp_hm = d[hm_w-1:0];
            search_bus_pkg::addr_board_lo,
            search_bus_pkg::addr_board_hi:
            begin
               base = (a == search_bus_pkg::addr_board_hi) ? 128 : 0;
               for (int b = 0; b < 16; b++)
               begin
                  if (be[b])
                     exp_board[base + 8*b +: 8] = d[8*b +: 8];
               end
            end
            search_bus_pkg::addr_tt_entry:  exp_entry = {d[63:61], 1'b1, d[59:0]};
            search_bus_pkg::addr_tt_strobe: exp_cmd = d[3:0];
            default:                        exp_cmd = 4'h0;
         endcase
      end
   endtask

   function automatic logic [127:0] expected_read(input search_bus_pkg::reg_addr_t a);
      logic [127:0] w;
      w = '0;
      case (a)
         search_bus_pkg::addr_command:
         begin
            w[0]  = exp_nbv;
            w[1]  = exp_clr;
            w[2]  = st_v.moves_ready;
            w[3]  = st_v.move_ready;
            w[4]  = st_v.initial_stalemate;
            w[5]  = st_v.initial_mate;
            w[7]  = st_v.idle;
            w[31] = exp_srst;
         end
         search_bus_pkg::addr_move_index:      w[mi_w-1:0] = exp_mi;
         search_bus_pkg::addr_position:        w[8:0] = exp_pos;
         search_bus_pkg::addr_half_move:       w[hm_w-1:0] = exp_hm;
         search_bus_pkg::addr_attack_white_lo: w[31:0] = st_v.white_attack[31:0];
         search_bus_pkg::addr_attack_white_hi: w[31:0] = st_v.white_attack[63:32];
         search_bus_pkg::addr_attack_black_lo: w[31:0] = st_v.black_attack[31:0];
         search_bus_pkg::addr_attack_black_hi: w[31:0] = st_v.black_attack[63:32];
         search_bus_pkg::addr_move_flags:
         begin
            w[0] = st_v.flags.capture;
            w[1] = st_v.flags.white_in_check;
            w[2] = st_v.flags.black_in_check;
            w[3] = st_v.flags.thrice_rep;
            w[4] = st_v.flags.fifty_move;
            w[5] = st_v.flags.insufficient_material;
            w[6] = st_v.flags.pv;
         end
         search_bus_pkg::addr_mg_position:
         begin
            w[8]   = st_v.white_to_move;
            w[7:4] = st_v.castle_mask;
            w[3:0] = st_v.en_passant_col;
         end
         search_bus_pkg::addr_eval:         w[31:0] = {{8{st_v.eval[23]}}, st_v.eval};
         search_bus_pkg::addr_move_count:   w[mi_w-1:0] = st_v.move_count[mi_w-1:0];
         search_bus_pkg::addr_initial_eval:
            w[31:0] = {{8{st_v.initial_eval[23]}}, st_v.initial_eval};
         search_bus_pkg::addr_uci:
         begin
            for (int f = 0; f < 4; f++)
               w[4*f +: 3] = st_v.uci[3*f +: 3]; // zero gap above each field
            w[19:16] = st_v.uci[15:12];
         end
         search_bus_pkg::addr_tt_result:
         begin
            w[23:0]  = tr_v.result.eval;
            w[31:24] = tr_v.result.depth;
            w[59:32] = tr_v.result.nodes;
            w[60]    = tr_v.entry_valid;
            w[62:61] = tr_v.result.flag;
            w[63]    = tr_v.collision;
         end
         search_bus_pkg::addr_tt_status:    w[1:0] = {tr_v.capture, tr_v.idle};
         default:                           w = '0;
      endcase
      return w;
   endfunction

   task automatic check_outputs(input string name);
      check_value({name, " command"}, 256'({exp_nbv, exp_clr, exp_srst}),
                  256'({new_board_valid, clear_moves, soft_reset}));
      check_value({name, " move index"}, 256'(exp_mi), 256'(move_index));
      check_value({name, " half move"}, 256'(exp_hm), 256'(half_move));
      check_value({name, " side castle ep"}, 256'(exp_pos),
                  256'({position.white_to_move, position.castle_mask, position.en_passant_col}));
      check_value({name, " board"}, exp_board, 256'(position.board));
      check_value({name, " tt entry"}, 256'(exp_entry), 256'(tt_entry));
      check_value({name, " tt strobes"}, 256'(exp_cmd), 256'(tt_cmd));
   endtask

   task automatic write_reg(input search_bus_pkg::reg_addr_t a, input logic [127:0] d,
                            input logic [15:0] be);
      @(posedge clk);
      req.addr  <= {a, 4'h0};
      req.wdata <= d;
      req.en    <= 1'b1;
      req.be    <= be;
      @(posedge clk);
      req.en <= 1'b0;
      req.be <= '0;
      model_write(a, d, be);
      @(negedge clk);
      check_outputs($sformatf("write %0d", a));
   endtask

   task automatic read_check(input search_bus_pkg::reg_addr_t a);
      @(posedge clk);
      req.addr <= {a, 4'h0};
      @(posedge clk);
      @(negedge clk);
      check_value($sformatf("read %0d", a), 256'(expected_read(a)), 256'(rdata));
   endtask

   task automatic load_status();
      logic [255:0] r;
      r    = {rand_data(), rand_data()};
      st_v = r[$bits(search_pos_pkg::movegen_status_t)-1:0];
      r    = {rand_data(), rand_data()};
      tr_v = r[$bits(search_pos_pkg::tt_result_t)-1:0];
      @(posedge clk);
      status    <= st_v;
      tt_result <= tr_v;
   endtask

   initial
   begin
      rst_n     <= 1'b0;
      req       <= '0;
      status    <= '0;
      tt_result <= '0;
      exp_nbv   = 1'b0;
      exp_clr   = 1'b0;
      exp_srst  = 1'b0;
      exp_mi    = '0;
      exp_hm    = '0;
      exp_pos   = '0;
      exp_board = '0;
      exp_entry = '0;
      exp_cmd   = '0;
      st_v      = '0;
      tr_v      = '0;
      repeat (reset_cycles) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_outputs("reset");
      check_value("reset rdata", 256'(0), 256'(rdata));
      for (int i = 0; i < n_iter; i++)
      begin
         load_status();
         write_reg(search_bus_pkg::addr_command, rand_data(), rand_be());
         write_reg(search_bus_pkg::addr_move_index, rand_data(), rand_be());
         write_reg(search_bus_pkg::addr_position, rand_data(), rand_be());
         write_reg(search_bus_pkg::addr_half_move, rand_data(), rand_be());
         write_reg(search_bus_pkg::addr_move_index, rand_data(), 16'h0000); // dropped
         write_reg(search_bus_pkg::addr_board_lo, rand_data(), rand_be());
         write_reg(search_bus_pkg::addr_board_hi, rand_data(), rand_be());
         write_reg(search_bus_pkg::addr_tt_entry, rand_data(), rand_be());
         write_reg(search_bus_pkg::addr_tt_strobe, rand_data(), 16'hffff);
         @(negedge clk);
         check_value("strobe one cycle", 256'(0), 256'(tt_cmd));
         foreach (read_addrs[k])
            read_check(read_addrs[k]);
         read_check(search_bus_pkg::reg_addr_t'(rand_be()) | 14'h0400); // above the map
      end
      if (search_ctrl_top_i.search_ctrl_asserts_i.fail_count == 0)
      begin
         $display("Simulation PASSED");
         $finish;
      end
      else
      begin
         $display("bound assertions reported failures");
         $display("Simulation FAILED");
         $fatal(1, "bound assertion");
      end
   end

endmodule

/* vlog.f */
src/search_pos_pkg.sv
src/search_bus_pkg.sv
src/ctrl_write_decode.sv
src/position_regs.sv
src/tt_request_regs.sv
src/ctrl_read_mux.sv
src/search_ctrl_top.sv
test/search_ctrl_asserts.sv
test/search_ctrl_tb.sv
